// File: all.f
source/ppu_timing_pkg.sv
source/ppu_regs_pkg.sv
source/frame_timer.sv
source/vram_addr_regs.sv
source/bg_shifter.sv
source/palette_ram.sv
source/ppu_top.sv
bench/ppu_tb.sv

// File: Bender.yml
package:
  name: ppu_bg

sources:
  - source/ppu_timing_pkg.sv
  - source/ppu_regs_pkg.sv
  - source/frame_timer.sv
  - source/vram_addr_regs.sv
  - source/bg_shifter.sv
  - source/palette_ram.sv
  - source/ppu_top.sv
  - target: simulation
    files:
      - bench/ppu_tb.sv

// File: bench/ppu_tb.sv
/* Testbench for the background PPU, video memory answers combinationally from vram_addr
   Fails at the first mismatch or timeout */
`timescale 1ns/1ps

module ppu_tb;
  import ppu_timing_pkg::*;
  import ppu_regs_pkg::*;

  logic                 clk       = 1'b0;
  logic                 reset     = 1'b1;
  logic [2:0]           cpu_addr  = 3'd0;
  logic [7:0]           cpu_din   = 8'h00;
  logic                 cpu_read  = 1'b0;
  logic                 cpu_write = 1'b0;
  logic [7:0]           vram_din;               // Memory model output
  logic [7:0]           cpu_dout, vram_dout;
  logic                 nmi, vram_read, vram_write;
  logic [VRAM_AW-1:0]   vram_addr;
  logic [COLOR_W-1:0]   color;
  logic [COORD_W-1:0]   scanline, cycle;

  logic [7:0]           vram_mem [2**VRAM_AW];  // Video memory model
  logic [COLOR_W-1:0]   ref_pal [2**PAL_AW];    // Expected palette contents
  integer               seed = 32'hfd47;
  logic                 track_frame = 1'b0;     // Frame counter compare enable
  int                   frames_seen = 0;
  logic [COORD_W-1:0]   exp_line    = '0;
  logic [COORD_W-1:0]   exp_cycle   = '0;
  logic                 seen_write;             // VRAM bus as seen mid access
  logic                 seen_read;
  logic [VRAM_AW-1:0]   seen_addr;
  logic [7:0]           seen_dout;

  always #5 clk = ~clk;

  ppu_top ppu_top_inst (
    .clk (clk), .reset (reset),
    .cpu_addr (cpu_addr), .cpu_din (cpu_din), .cpu_read (cpu_read), .cpu_write (cpu_write),
    .vram_din (vram_din), .cpu_dout (cpu_dout), .nmi (nmi),
    .vram_read (vram_read), .vram_write (vram_write), .vram_addr (vram_addr),
    .vram_dout (vram_dout), .color (color), .scanline (scanline), .cycle (cycle)
  );

  assign vram_din = vram_mem[vram_addr];

  always @(posedge clk) begin
    if (vram_write)
      vram_mem[vram_addr] <= vram_dout;
  end

  // 341 cycles per line, lines 0..260 then -1
  function automatic logic [2*COORD_W-1:0] next_position(input logic [COORD_W-1:0] line,
                                                         input logic [COORD_W-1:0] cyc);
    logic [COORD_W-1:0] nl;
    logic [COORD_W-1:0] nc;
    nl = line;
    nc = cyc + 1'b1;
    if (cyc == 9'd340) begin
      nc = '0;
      nl = (line == 9'd260) ? 9'd511 : line + 1'b1;  // 511 wraps to 0 by itself
    end
    return {nl, nc};
  endfunction

  function automatic logic [13:0] next_vram_addr(input logic [13:0] a, input logic step32);
    return a + (step32 ? 14'd32 : 14'd1);
  endfunction

  function automatic logic [7:0] fill_byte(input logic [13:0] a);
    return a[7:0] ^ {a[13:8], a[13:12]};
  endfunction

  // Low bits 00 read the backdrop
  function automatic logic [COLOR_W-1:0] palette_color(input logic [4:0] p, input logic gray);
    logic [COLOR_W-1:0] c;
    c = (p[1:0] == 2'b00) ? ref_pal[0] : ref_pal[p];
    return gray ? {c[5:4], 4'b0000} : c;
  endfunction

  task automatic store_palette(input logic [4:0] p, input logic [COLOR_W-1:0] c);
    if (p[1:0] != 2'b00)
      ref_pal[p] = c;
    else if (p[3:2] == 2'b00)
      ref_pal[0] = c;  // 0 and 16 share the backdrop, other mirrors drop the write
  endtask

  task automatic stop_run;
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    stop_run();
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    stop_run();
  endtask

  // One-cycle strobe, outputs sampled at the falling edge
  task automatic cpu_access(input logic wr, input logic [2:0] reg_num, input logic [7:0] data,
                            output logic [7:0] rdata);
    @(posedge clk);
    cpu_addr  <= reg_num;
    cpu_din   <= data;
    cpu_write <= wr;
    cpu_read  <= !wr;
    @(negedge clk);
    rdata      = cpu_dout;
    seen_write = vram_write;
    seen_read  = vram_read;
    seen_addr  = vram_addr;
    seen_dout  = vram_dout;
    @(posedge clk);
    cpu_write <= 1'b0;
    cpu_read  <= 1'b0;
  endtask

  task automatic write_reg(input logic [2:0] reg_num, input logic [7:0] data);
    logic [7:0] ignored;
    cpu_access(1'b1, reg_num, data, ignored);
  endtask

  task automatic set_vram_address(input logic [13:0] a);
    write_reg(REG_ADDR, {2'b00, a[13:8]});  // High byte first
    write_reg(REG_ADDR, a[7:0]);
  endtask

  // Compares the counters every cycle while enabled
  always @(negedge clk) begin
    if (track_frame) begin
      assert (scanline == exp_line && cycle == exp_cycle)
        else report_mismatch("frame counter", {exp_line, exp_cycle}, {scanline, cycle});
      {exp_line, exp_cycle} = next_position(exp_line, exp_cycle);
      if (exp_line == 9'd0 && exp_cycle == 9'd0)
        frames_seen = frames_seen + 1;
    end
  end

  initial begin
    logic [7:0]  rd;
    logic [31:0] rnd;
    logic [13:0] base;
    logic [13:0] exp_addr;
    int          waited;
    for (int a = 0; a < 2**VRAM_AW; a++)
      vram_mem[a] = fill_byte(a[13:0]);
    repeat (4) @(posedge clk);
    reset       <= 1'b0;
    track_frame  = 1'b1;  // First compare sees the reset position
    waited       = 0;
    while (frames_seen < 2) begin
      @(posedge clk);
      waited++;
      if (waited > 200000) report_timeout("two frames of the counter");
    end
    track_frame = 1'b0;

    write_reg(REG_CTRL, 8'h80);  // NMI enable
    waited = 0;
    @(negedge clk);
    while (!(scanline == 9'd240 && cycle == 9'd340)) begin
      @(negedge clk);
      waited++;
      if (waited > 100000) report_timeout("end of line 240");
    end
    assert (nmi == 1'b0) else report_mismatch("nmi before vblank", 0, nmi);
    @(negedge clk);
    assert (nmi == 1'b1) else report_mismatch("nmi at vblank", 1, nmi);
    cpu_access(1'b0, REG_STATUS, 8'h00, rd);
    assert (rd == 8'h80) else report_mismatch("status vblank set", 8'h80, rd);
    @(negedge clk);
    assert (nmi == 1'b0) else report_mismatch("nmi after status read", 0, nmi);
    cpu_access(1'b0, REG_STATUS, 8'h00, rd);
    assert (rd == 8'h00) else report_mismatch("status vblank clear", 8'h00, rd);

    for (int pass = 0; pass < 2; pass++) begin
      write_reg(REG_CTRL, (pass == 1) ? 8'h04 : 8'h00);  // Step 1, then 32
      rnd      = $random(seed);
      base     = rnd[13:0] % 14'h3000;  // Stays clear of palette space
      exp_addr = base;
      set_vram_address(base);
      for (int i = 0; i < 6; i++) begin
        rnd = $random(seed);
        write_reg(REG_DATA, rnd[7:0]);
        assert (seen_write) else report_mismatch("vram write strobe", 1, seen_write);
        assert (seen_addr == exp_addr)
          else report_mismatch("vram write address", exp_addr, seen_addr);
        assert (seen_dout == rnd[7:0])
          else report_mismatch("vram write data", rnd[7:0], seen_dout);
        exp_addr = next_vram_addr(exp_addr, pass == 1);
      end
    end

    write_reg(REG_CTRL, 8'h00);
    for (int a = 0; a < 2**VRAM_AW; a++)
      vram_mem[a] = fill_byte(a[13:0]);
    rnd  = $random(seed);
    base = rnd[13:0] % 14'h3000;
    set_vram_address(base);
    cpu_access(1'b0, REG_DATA, 8'h00, rd);
    assert (rd == 8'h00) else report_mismatch("stale read latch", 8'h00, rd);  // Nothing read yet
    assert (seen_read) else report_mismatch("vram read strobe", 1, seen_read);
    assert (seen_addr == base) else report_mismatch("vram read address", base, seen_addr);
    for (int i = 0; i < 3; i++) begin
      cpu_access(1'b0, REG_DATA, 8'h00, rd);
      assert (rd == fill_byte(base + i))
        else report_mismatch("read latch", fill_byte(base + i), rd);
      assert (seen_read) else report_mismatch("vram read strobe", 1, seen_read);
      assert (seen_addr == base + i + 1)
        else report_mismatch("vram read address", base + i + 1, seen_addr);
    end

    set_vram_address(14'h3F00);
    for (int p = 0; p < 2**PAL_AW; p++) begin
      rnd = $random(seed);
      write_reg(REG_DATA, rnd[7:0]);
      assert (!seen_write) else report_mismatch("palette write strobe", 0, seen_write);
      store_palette(p[4:0], rnd[5:0]);
    end
    set_vram_address(14'h3F00);
    for (int p = 0; p < 2**PAL_AW; p++) begin
      cpu_access(1'b0, REG_DATA, 8'h00, rd);
      assert (rd == {2'b00, palette_color(p[4:0], 1'b0)})
        else report_mismatch("palette read", {2'b00, palette_color(p[4:0], 1'b0)}, rd);
    end
    write_reg(REG_MASK, 8'h01);  // Grayscale
    set_vram_address(14'h3F00);
    for (int p = 0; p < 8; p++) begin
      cpu_access(1'b0, REG_DATA, 8'h00, rd);
      assert (rd == {2'b00, palette_color(p[4:0], 1'b1)})
        else report_mismatch("palette gray", {2'b00, palette_color(p[4:0], 1'b1)}, rd);
    end
    write_reg(REG_MASK, 8'h00);

    // Solid tiles of pixel value 3, attribute 0 everywhere
    for (int a = 0; a < 2**VRAM_AW; a++)
      vram_mem[a] = (a < 'h2000) ? 8'hFF : 8'h00;
    rnd = $random(seed);
    set_vram_address(14'h3F03);
    write_reg(REG_DATA, rnd[7:0]);
    store_palette(5'd3, rnd[5:0]);
    write_reg(REG_MASK, 8'h08);  // Background on, left 8 pixels hidden
    waited = 0;
    while (scanline != 9'd511) begin
      @(negedge clk);
      waited++;
      if (waited > 100000) report_timeout("pre-render line");
    end
    while (scanline != 9'd0) begin
      @(negedge clk);
      waited++;
      if (waited > 100000) report_timeout("first visible line");
    end
    waited = 0;
    while (scanline != 9'd240) begin
      if (cycle >= 9'd32 && cycle <= 9'd255)
        assert (color == palette_color(5'd3, 1'b0))
          else report_mismatch("background color", palette_color(5'd3, 1'b0), color);
      else if (cycle < 9'd8)
        assert (color == palette_color(5'd0, 1'b0))
          else report_mismatch("left edge backdrop", palette_color(5'd0, 1'b0), color);
      @(negedge clk);
      waited++;
      if (waited > 100000) report_timeout("end of visible lines");
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: source/ppu_top.sv
/* Background-only PPU, one pixel per clock, sprites not present
   CPU strobes are single-cycle, status reports only the vblank flag */
`timescale 1ns/1ps

module ppu_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [2:0]                        cpu_addr,
  input  logic [7:0]                        cpu_din,
  input  logic                              cpu_read,
  input  logic                              cpu_write,
  input  logic [7:0]                        vram_din,
  output logic [7:0]                        cpu_dout,
  output logic                              nmi,
  output logic                              vram_read,
  output logic                              vram_write,
  output logic [ppu_regs_pkg::VRAM_AW-1:0]  vram_addr,
  output logic [7:0]                        vram_dout,
  output logic [ppu_regs_pkg::COLOR_W-1:0]  color,
  output logic [ppu_timing_pkg::COORD_W-1:0] scanline,
  output logic [ppu_timing_pkg::COORD_W-1:0] cycle
);
  import ppu_timing_pkg::*;
  import ppu_regs_pkg::*;

  // Control and mask bits
  logic bg_patt, nmi_en, incr_32;
  logic gray, bg_clip, bg_en;

  logic       nmi_occurred;  // Set at vblank entry, cleared by status read
  logic [7:0] read_latch;    // Buffered REG_DATA value

  logic in_vblank, pre_render, end_of_line, last_cycle_group;
  logic entering_vblank, exiting_vblank;
  logic rendering;

  logic ctrl_write, mask_write, scroll_write, addr_write, status_read;
  logic data_sel, data_access, pal_space;

  vram_addr_t         cur_addr;
  logic [2:0]         fine_x;
  logic [7:0]         tile_index;
  logic [3:0]         bg_raw;
  logic [3:0]         bg_pixel;     // After left-edge clip
  logic               show_bg;
  logic [PAL_AW-1:0]  pal_addr;
  logic               pal_write;
  logic [COLOR_W-1:0] pal_color;

  assign rendering = bg_en && !in_vblank && (scanline != POST_RENDER_LINE);

  // Register decode
  assign ctrl_write   = cpu_write && (cpu_addr == REG_CTRL);
  assign mask_write   = cpu_write && (cpu_addr == REG_MASK);
  assign scroll_write = cpu_write && (cpu_addr == REG_SCROLL);
  assign addr_write   = cpu_write && (cpu_addr == REG_ADDR);
  assign status_read  = cpu_read && (cpu_addr == REG_STATUS);
  assign data_sel     = (cpu_addr == REG_DATA);
  assign data_access  = (cpu_read || cpu_write) && data_sel && !rendering;
  assign pal_space    = (cur_addr.flat[13:8] == PALETTE_PAGE);

  frame_timer frame_timer_inst (
    .clk              (clk),
    .reset            (reset),
    .rendering        (rendering),
    .scanline         (scanline),
    .cycle            (cycle),
    .in_vblank        (in_vblank),
    .pre_render       (pre_render),
    .end_of_line      (end_of_line),
    .last_cycle_group (last_cycle_group),
    .entering_vblank  (entering_vblank),
    .exiting_vblank   (exiting_vblank)
  );

  vram_addr_regs vram_addr_regs_inst (
    .clk          (clk),
    .reset        (reset),
    .rendering    (rendering),
    .pre_render   (pre_render),
    .cycle        (cycle),
    .ctrl_write   (ctrl_write),
    .scroll_write (scroll_write),
    .addr_write   (addr_write),
    .status_read  (status_read),
    .data_access  (data_access),
    .incr_32      (incr_32),
    .cpu_din      (cpu_din),
    .vram_addr    (cur_addr),
    .fine_x       (fine_x)
  );

  // Shifting pauses over the last cycle group
  bg_shifter bg_shifter_inst (
    .clk        (clk),
    .reset      (reset),
    .shift_en   (!last_cycle_group),
    .cycle      (cycle),
    .fine_x     (fine_x),
    .vram_addr  (cur_addr),
    .vram_din   (vram_din),
    .tile_index (tile_index),
    .pixel      (bg_raw)
  );

  // Pixels 0..7 drop to backdrop unless clip bit set
  assign show_bg  = bg_clip || (cycle[7:3] != 5'd0);
  assign bg_pixel = {bg_raw[3:2], show_bg ? bg_raw[1:0] : 2'b00};

  // Fetch order per tile: name, attribute, pattern lo, pattern hi
  always_comb begin
    if (!rendering)
      vram_addr = cur_addr.flat[13:0];
    else if (cycle[2:1] == 2'b00)
      vram_addr = {NAMETABLE_BASE, cur_addr.flat[11:0]};
    else if (cycle[2:1] == 2'b01)
      vram_addr = {NAMETABLE_BASE, cur_addr.scroll.nametable, 4'b1111,
                   cur_addr.scroll.coarse_y[4:2], cur_addr.scroll.coarse_x[4:2]};
    else
      vram_addr = {1'b0, bg_patt, tile_index, cycle[1], cur_addr.scroll.fine_y};
  end

  assign vram_read  = (cpu_read && data_sel) || (rendering && !cycle[0] && !end_of_line);
  assign vram_write = cpu_write && data_sel && !rendering && !pal_space;
  assign vram_dout  = cpu_din;

  assign pal_addr  = rendering ? {1'b0, bg_pixel} : (pal_space ? cur_addr.flat[4:0] : '0);
  assign pal_write = cpu_write && data_sel && !rendering && pal_space;

  palette_ram palette_ram_inst (
    .clk   (clk),
    .addr  (pal_addr),
    .write (pal_write),
    .din   (cpu_din[COLOR_W-1:0]),
    .dout  (pal_color)
  );

  assign color = gray ? {pal_color[5:4], 4'b0000} : pal_color; // Hue dropped, luma kept

  always_ff @(posedge clk) begin
    if (reset) begin
      {bg_patt, nmi_en, incr_32} <= '0;
      {gray, bg_clip, bg_en}     <= '0;
      nmi_occurred               <= 1'b0;
      read_latch                 <= '0;
    end else begin
      if (ctrl_write) begin
        bg_patt <= cpu_din[CTRL_BG_PATT];
        nmi_en  <= cpu_din[CTRL_NMI_EN];
        incr_32 <= cpu_din[CTRL_INCR_32];
      end
      if (mask_write) begin
        gray    <= cpu_din[MASK_GRAY];
        bg_clip <= cpu_din[MASK_BG_CLIP];
        bg_en   <= cpu_din[MASK_BG_EN];
      end
      if (entering_vblank)
        nmi_occurred <= 1'b1;
      else if (exiting_vblank || status_read)
        nmi_occurred <= 1'b0;
      // Memory answers during the read strobe, latch holds it from the next cycle
      if (cpu_read && data_access)
        read_latch <= vram_din;
    end
  end

  assign nmi = nmi_occurred && nmi_en;

  always_comb begin
    if (cpu_addr == REG_STATUS)
      cpu_dout = {nmi_occurred, 7'b0000000};
    else if (pal_space)
      cpu_dout = {2'b00, color}; // Palette bypasses the latch
    else
      cpu_dout = read_latch;
  end

endmodule

// File: source/palette_ram.sv
/* 32-entry color RAM, combinational read
   Every entry with low bits 00 reads as backdrop entry 0 */
`timescale 1ns/1ps

module palette_ram (
  input  logic                             clk,
  input  logic [ppu_regs_pkg::PAL_AW-1:0]  addr,
  input  logic                             write,
  input  logic [ppu_regs_pkg::COLOR_W-1:0] din,
  output logic [ppu_regs_pkg::COLOR_W-1:0] dout
);
  import ppu_regs_pkg::*;

  logic [COLOR_W-1:0] colors [2**PAL_AW];
  logic [PAL_AW-1:0]  eff_addr;   // Backdrop redirect
  logic               write_ok;

  assign eff_addr = (addr[1:0] == 2'b00) ? '0 : addr;
  assign dout     = colors[eff_addr];

  // Entries 4/8/12/20/24/28 are read-only mirrors, 0 and 16 both hit entry 0
  assign write_ok = !(addr[3:2] != 2'b00 && addr[1:0] == 2'b00);

  always_ff @(posedge clk) begin
    if (write && write_ok)
      colors[eff_addr] <= din;
  end

endmodule

// File: source/bg_shifter.sv
/* Background tile fetch registers and pixel shifters
   Output pixel lags its fetch by about two tiles, depending on fine X */
`timescale 1ns/1ps

module bg_shifter (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              shift_en,
  input  logic [ppu_timing_pkg::COORD_W-1:0] cycle,
  input  logic [2:0]                        fine_x,
  input  ppu_regs_pkg::vram_addr_t          vram_addr,
  input  logic [7:0]                        vram_din,
  output logic [7:0]                        tile_index,
  output logic [3:0]                        pixel
);
  import ppu_regs_pkg::*;

  logic [2:0]  phase;
  logic [1:0]  quadrant;   // Attribute byte holds 4 quadrants of 2x2 tiles
  logic [1:0]  attr_bits;
  logic [7:0]  patt_lo;    // First pattern plane
  logic [15:0] pipe_lo;    // Pattern plane 0
  logic [15:0] pipe_hi;    // Pattern plane 1
  logic [8:0]  pipe_at0;   // Attribute bit 0
  logic [8:0]  pipe_at1;   // Attribute bit 1

  // Leftmost pixel is bit 7 in memory, shifters output LSB first
  function automatic logic [7:0] reverse8(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++)
      r[i] = b[7 - i];
    return r;
  endfunction

  assign phase    = cycle[2:0];
  assign quadrant = {vram_addr.scroll.coarse_y[1], vram_addr.scroll.coarse_x[1]};

  always_ff @(posedge clk) begin
    if (reset) begin
      tile_index <= '0;
      attr_bits  <= '0;
      patt_lo    <= '0;
      pipe_lo    <= '0;
      pipe_hi    <= '0;
      pipe_at0   <= '0;
      pipe_at1   <= '0;
    end else begin
      case (phase)
        3'd1:    tile_index <= vram_din;                   // Name byte
        3'd3:    attr_bits  <= vram_din[quadrant*2 +: 2];
        3'd5:    patt_lo    <= vram_din;
        default: ;
      endcase
      if (shift_en) begin
        pipe_lo[14:0] <= pipe_lo[15:1];
        pipe_hi[14:0] <= pipe_hi[15:1];
        pipe_at0[7:0] <= pipe_at0[8:1];
        pipe_at1[7:0] <= pipe_at1[8:1];
        if (phase == 3'd7) begin
          pipe_lo[15:8] <= reverse8(patt_lo);
          pipe_hi[15:8] <= reverse8(vram_din); // Second plane arrives now
          pipe_at0[8]   <= attr_bits[0];
          pipe_at1[8]   <= attr_bits[1];
        end
      end
    end
  end

  // Fine X picks the tap
  assign pixel = {pipe_at1[fine_x], pipe_at0[fine_x], pipe_hi[fine_x], pipe_lo[fine_x]};

endmodule

// File: source/vram_addr_regs.sv
/* Current/temporary VRAM address, fine X and the shared write toggle
   data_access must already be suppressed by the caller while rendering */
`timescale 1ns/1ps

module vram_addr_regs (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              rendering,
  input  logic                              pre_render,
  input  logic [ppu_timing_pkg::COORD_W-1:0] cycle,
  input  logic                              ctrl_write,
  input  logic                              scroll_write,
  input  logic                              addr_write,
  input  logic                              status_read,
  input  logic                              data_access,
  input  logic                              incr_32,
  input  logic [7:0]                        cpu_din,
  output ppu_regs_pkg::vram_addr_t          vram_addr,
  output logic [2:0]                        fine_x
);
  import ppu_timing_pkg::*;
  import ppu_regs_pkg::*;

  vram_addr_t cur_addr;      // v
  vram_addr_t tmp_addr;      // t
  logic       second_write;  // Toggle shared by scroll and address
  logic       coarse_x_step;
  logic       fetch_range;

  // Step after the attribute fetch of each tile
  assign fetch_range   = (cycle < VISIBLE_CYCLES) ||
                         (cycle >= PREFETCH_START && cycle < PREFETCH_END);
  assign coarse_x_step = (cycle[2:0] == 3'd3) && fetch_range;

  always_ff @(posedge clk) begin
    if (reset) begin
      cur_addr     <= '0;
      tmp_addr     <= '0;
      fine_x       <= '0;
      second_write <= 1'b0;
    end else begin
      if (rendering) begin
        if (coarse_x_step) begin
          cur_addr.scroll.coarse_x <= cur_addr.scroll.coarse_x + 5'd1;
          if (cur_addr.scroll.coarse_x == 5'd31)
            cur_addr.scroll.nametable[0] <= ~cur_addr.scroll.nametable[0]; // Next table across
        end
        if (cycle == VERT_INC_CYCLE) begin
          cur_addr.scroll.fine_y <= cur_addr.scroll.fine_y + 3'd1;
          if (cur_addr.scroll.fine_y == 3'd7) begin
            // Row 29 is the last tile row, attribute rows are skipped
            if (cur_addr.scroll.coarse_y == 5'd29) begin
              cur_addr.scroll.coarse_y     <= 5'd0;
              cur_addr.scroll.nametable[1] <= ~cur_addr.scroll.nametable[1];
            end else begin
              cur_addr.scroll.coarse_y <= cur_addr.scroll.coarse_y + 5'd1;
            end
          end
        end
        if (cycle == HORIZ_COPY_CYCLE) begin
          cur_addr.scroll.coarse_x     <= tmp_addr.scroll.coarse_x;
          cur_addr.scroll.nametable[0] <= tmp_addr.scroll.nametable[0];
        end
        if (cycle == VERT_COPY_CYCLE && pre_render)
          cur_addr <= tmp_addr; // Whole frame restarts from t
      end

      // CPU side
      if (ctrl_write) begin
        tmp_addr.scroll.nametable <= cpu_din[CTRL_NT_LO +: 2];
      end else if (scroll_write) begin
        if (!second_write) begin
          tmp_addr.scroll.coarse_x <= cpu_din[7:3];
          fine_x                   <= cpu_din[2:0];
        end else begin
          tmp_addr.scroll.coarse_y <= cpu_din[7:3];
          tmp_addr.scroll.fine_y   <= cpu_din[2:0];
        end
        second_write <= ~second_write;
      end else if (addr_write) begin
        if (!second_write) begin
          tmp_addr.flat[13:8] <= cpu_din[5:0]; // High byte first
          tmp_addr.flat[14]   <= 1'b0;
        end else begin
          tmp_addr.flat[7:0] <= cpu_din;
          cur_addr.flat      <= {tmp_addr.flat[14:8], cpu_din}; // Takes effect now
        end
        second_write <= ~second_write;
      end else if (status_read) begin
        second_write <= 1'b0;
      end else if (data_access) begin
        cur_addr.flat <= cur_addr.flat + (incr_32 ? 15'd32 : 15'd1); // Row or column step
      end
    end
  end

  assign vram_addr = cur_addr;

endmodule

// File: source/frame_timer.sv
/* Scanline/cycle counter, 341 cycles by 262 lines
   Odd frames drop one cycle of the pre-render line only while rendering */
`timescale 1ns/1ps

module frame_timer (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              rendering,
  output logic [ppu_timing_pkg::COORD_W-1:0] scanline,
  output logic [ppu_timing_pkg::COORD_W-1:0] cycle,
  output logic                              in_vblank,
  output logic                              pre_render,
  output logic                              end_of_line,
  output logic                              last_cycle_group,
  output logic                              entering_vblank,
  output logic                              exiting_vblank
);
  import ppu_timing_pkg::*;

  logic                odd_frame;  // Frame parity
  logic                short_line; // Odd pre-render line while rendering
  logic [COORD_W-1:0]  line_last;  // Last cycle of the current line

  assign last_cycle_group = (cycle[COORD_W-1:3] == LAST_CYCLE_GROUP);
  assign pre_render       = (scanline == PRE_RENDER_LINE);
  assign short_line       = pre_render && odd_frame && rendering;
  assign line_last        = short_line ? COORD_W'(LINE_END_CYCLE - 1) : COORD_W'(LINE_END_CYCLE);
  assign end_of_line      = (cycle == line_last);

  // Single-cycle events on the last cycle of a line
  assign entering_vblank = end_of_line && (scanline == POST_RENDER_LINE);
  assign exiting_vblank  = end_of_line && (scanline == VBLANK_END_LINE);

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle     <= '0;
      in_vblank <= 1'b1; // Starts as if vblank were running
    end else begin
      cycle <= end_of_line ? '0 : cycle + 1'b1;
      if (entering_vblank)
        in_vblank <= 1'b1;
      else if (exiting_vblank)
        in_vblank <= 1'b0;
    end
  end

  // Line counter, 260 jumps to -1 and -1 wraps to 0 by itself
  always_ff @(posedge clk) begin
    if (reset) begin
      scanline  <= '0;
      odd_frame <= 1'b0;
    end else if (end_of_line) begin
      scanline <= exiting_vblank ? PRE_RENDER_LINE : scanline + 1'b1;
      if (exiting_vblank)
        odd_frame <= ~odd_frame;
    end
  end

endmodule

// File: source/ppu_regs_pkg.sv
/* CPU register map, control/mask bits and video memory layout
   Only background bits are decoded, object bits read as don't care */
package ppu_regs_pkg;

  // CPU register numbers
  localparam logic [2:0] REG_CTRL   = 3'd0;
  localparam logic [2:0] REG_MASK   = 3'd1;
  localparam logic [2:0] REG_STATUS = 3'd2;
  localparam logic [2:0] REG_SCROLL = 3'd5;
  localparam logic [2:0] REG_ADDR   = 3'd6;
  localparam logic [2:0] REG_DATA   = 3'd7;

  // Control byte, nametable select is two bits from CTRL_NT_LO
  localparam int CTRL_NT_LO   = 0;
  localparam int CTRL_INCR_32 = 2;
  localparam int CTRL_BG_PATT = 4;
  localparam int CTRL_NMI_EN  = 7;

  // Mask byte
  localparam int MASK_GRAY    = 0;
  localparam int MASK_BG_CLIP = 1; // Set shows background in pixels 0..7
  localparam int MASK_BG_EN   = 3;

  // Memory map
  localparam logic [5:0] PALETTE_PAGE   = 6'h3F; // Address bits 13:8
  localparam logic [1:0] NAMETABLE_BASE = 2'b10; // 0x2000 region
  localparam int VRAM_AW = 14;
  localparam int PAL_AW  = 5;
  localparam int COLOR_W = 6;

  // Scroll view of the VRAM address register
  typedef struct packed {
    logic [2:0] fine_y;
    logic [1:0] nametable; // Bit 0 horizontal, bit 1 vertical
    logic [4:0] coarse_y;
    logic [4:0] coarse_x;
  } scroll_fields_t;

  // Same register used as memory pointer and as scroll position
  typedef union packed {
    logic [14:0]    flat;
    scroll_fields_t scroll;
  } vram_addr_t;

endpackage

// File: source/ppu_timing_pkg.sv
/* Frame geometry of the background PPU, one clock per pixel
   Line numbers are 9-bit, the pre-render line is -1 (511) */
package ppu_timing_pkg;

  localparam int COORD_W = 9;  // Scanline and cycle width

  // Horizontal geometry
  localparam int LAST_CYCLE_GROUP = 42;  // Cycles 336..343, the line ends inside it
  localparam int LINE_END_CYCLE   = 340; // Odd pre-render line ends one earlier
  localparam int VISIBLE_CYCLES   = 256;
  localparam int PREFETCH_START   = 320; // First two tiles of next line
  localparam int PREFETCH_END     = 336;

  // Scroll register events while rendering
  localparam int VERT_INC_CYCLE   = 251;
  localparam int HORIZ_COPY_CYCLE = 256;
  localparam int VERT_COPY_CYCLE  = 304; // Pre-render line only

  // Vertical geometry
  localparam logic [COORD_W-1:0] POST_RENDER_LINE = 9'd240;
  localparam logic [COORD_W-1:0] VBLANK_END_LINE  = 9'd260;
  localparam logic [COORD_W-1:0] PRE_RENDER_LINE  = 9'd511;

endpackage
